// ==== include/requant_settings.svh ====
// Requantizer widths and dither constants
`ifndef REQUANT_SETTINGS_SVH
`define REQUANT_SETTINGS_SVH

// Sample widths. The dropped field is what lies between them.
`define REQUANT_IN_W   20
`define REQUANT_OUT_W  16
`define REQUANT_DROP_W 4

// Galois LFSR used as the dither threshold source.
`define DITHER_LFSR_W  16
`define DITHER_SEED    16'hACE1
`define DITHER_TAPS    16'hB400

`endif

// ==== design/requant_pkg.sv ====
// Requantizer shared types
package requant_pkg;

    // Rounding rule, chosen per sample. Encoding 3 behaves as truncate.
    typedef enum logic [1:0] {
        MODE_TRUNCATE = 2'd0,
        MODE_ROUND    = 2'd1,
        MODE_DITHER   = 2'd2
    } requant_mode_t;

endpackage

// ==== design/prefix_adder.sv ====
// Kogge-Stone prefix adder
`timescale 1ns/1ps

module prefix_adder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic             carry_out
);

    localparam int LEVELS = $clog2(WIDTH);

    // Group generate and propagate after each combining level.
    logic [WIDTH-1:0] g_lvl [0:LEVELS];
    logic [WIDTH-1:0] p_lvl [0:LEVELS-1];
    logic [WIDTH-1:0] carry;

    assign g_lvl[0] = a & b;
    assign p_lvl[0] = a ^ b;

    genvar lvl;
    genvar bit_idx;
    generate
        for (lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
            localparam int DIST = 1 << (lvl - 1);
            for (bit_idx = 0; bit_idx < WIDTH; bit_idx++) begin : g_bit
                if (bit_idx >= DIST) begin : g_combine
                    assign g_lvl[lvl][bit_idx] = g_lvl[lvl-1][bit_idx] |
                        (p_lvl[lvl-1][bit_idx] & g_lvl[lvl-1][bit_idx-DIST]);
                end else begin : g_pass
                    assign g_lvl[lvl][bit_idx] = g_lvl[lvl-1][bit_idx];
                end
                // The last level only needs generate, so propagate stops one short.
                if (lvl < LEVELS) begin : g_prop
                    if (bit_idx >= DIST) begin : g_prop_combine
                        assign p_lvl[lvl][bit_idx] = p_lvl[lvl-1][bit_idx] &
                            p_lvl[lvl-1][bit_idx-DIST];
                    end else begin : g_prop_pass
                        assign p_lvl[lvl][bit_idx] = p_lvl[lvl-1][bit_idx];
                    end
                end
            end
        end
    endgenerate

    // Carry into bit i is the prefix generate of bits i-1 down to 0.
    generate
        if (WIDTH > 1) begin : g_carry_wide
            assign carry = {g_lvl[LEVELS][WIDTH-2:0], 1'b0};
        end else begin : g_carry_narrow
            assign carry = 1'b0;
        end
    endgenerate

    assign sum       = p_lvl[0] ^ carry;
    assign carry_out = g_lvl[LEVELS][WIDTH-1];

endmodule

// ==== design/dither_source.sv ====
// Dither source and input stage
`timescale 1ns/1ps
`include "requant_settings.svh"

module dither_source (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [`REQUANT_IN_W-1:0]      in_sample,
    input  requant_pkg::requant_mode_t    in_mode,
    output logic                          s1_valid,
    output logic [`REQUANT_IN_W-1:0]      s1_sample,
    output requant_pkg::requant_mode_t    s1_mode,
    output logic [`REQUANT_DROP_W-1:0]    s1_dither
);

    logic [`DITHER_LFSR_W-1:0] lfsr;
    logic [`DITHER_LFSR_W-1:0] lfsr_next;

    // One Galois step shifts right, then folds in the taps if a one fell out.
    assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? `DITHER_TAPS : '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            lfsr     <= `DITHER_SEED;
        end else begin
            s1_valid <= in_valid;
            // Gap cycles leave the sequence where it is.
            if (in_valid) begin
                lfsr <= lfsr_next;
            end
        end
    end

    // The threshold is taken from the state before this sample's step.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_sample <= in_sample;
            s1_mode   <= in_mode;
            s1_dither <= lfsr[`REQUANT_DROP_W-1:0];
        end
    end

endmodule

// ==== design/requant_stage.sv ====
// Rounding decision stage
`timescale 1ns/1ps
`include "requant_settings.svh"

module requant_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          s1_valid,
    input  logic [`REQUANT_IN_W-1:0]      s1_sample,
    input  requant_pkg::requant_mode_t    s1_mode,
    input  logic [`REQUANT_DROP_W-1:0]    s1_dither,
    output logic                          s2_valid,
    output logic [`REQUANT_OUT_W-1:0]     s2_kept,
    output logic                          s2_round_up
);

    localparam logic [`REQUANT_DROP_W-1:0] HALF_STEP = 1'b1 << (`REQUANT_DROP_W - 1);

    logic [`REQUANT_OUT_W-1:0]  kept;
    logic [`REQUANT_DROP_W-1:0] dropped;
    logic                       round_up;

    assign kept    = s1_sample[`REQUANT_IN_W-1:`REQUANT_DROP_W];
    assign dropped = s1_sample[`REQUANT_DROP_W-1:0];

    always_comb begin
        case (s1_mode)
            requant_pkg::MODE_ROUND:  round_up = (dropped >= HALF_STEP);
            // Round up only when the dropped bits beat the random threshold.
            requant_pkg::MODE_DITHER: round_up = (dropped > s1_dither);
            default:                  round_up = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_kept     <= kept;
            s2_round_up <= round_up;
        end
    end

endmodule

// ==== design/increment_stage.sv ====
// Round-up increment and saturation stage
`timescale 1ns/1ps
`include "requant_settings.svh"

module increment_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      s2_valid,
    input  logic [`REQUANT_OUT_W-1:0] s2_kept,
    input  logic                      s2_round_up,
    output logic                      out_valid,
    output logic [`REQUANT_OUT_W-1:0] out_sample
);

    logic [`REQUANT_OUT_W-1:0] sum;
    logic                      carry;

    prefix_adder #(
        .WIDTH(`REQUANT_OUT_W)
    ) u_adder (
        .a         (s2_kept),
        .b         ({{(`REQUANT_OUT_W-1){1'b0}}, s2_round_up}),
        .sum       (sum),
        .carry_out (carry)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    // A carry means the sum wrapped past full scale, so clamp it.
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            out_sample <= carry ? '1 : sum;
        end
    end

endmodule

// ==== design/requant_top.sv ====
// Requantizer top level
`timescale 1ns/1ps
`include "requant_settings.svh"

module requant_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,
    input  logic [`REQUANT_IN_W-1:0]      in_sample,
    input  requant_pkg::requant_mode_t    in_mode,
    output logic                          out_valid,
    output logic [`REQUANT_OUT_W-1:0]     out_sample
);

    logic                          s1_valid;
    logic [`REQUANT_IN_W-1:0]      s1_sample;
    requant_pkg::requant_mode_t    s1_mode;
    logic [`REQUANT_DROP_W-1:0]    s1_dither;

    logic                          s2_valid;
    logic [`REQUANT_OUT_W-1:0]     s2_kept;
    logic                          s2_round_up;

    dither_source u_dither_source (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .in_mode   (in_mode),
        .s1_valid  (s1_valid),
        .s1_sample (s1_sample),
        .s1_mode   (s1_mode),
        .s1_dither (s1_dither)
    );

    requant_stage u_requant_stage (
        .clk         (clk),
        .reset       (reset),
        .s1_valid    (s1_valid),
        .s1_sample   (s1_sample),
        .s1_mode     (s1_mode),
        .s1_dither   (s1_dither),
        .s2_valid    (s2_valid),
        .s2_kept     (s2_kept),
        .s2_round_up (s2_round_up)
    );

    increment_stage u_increment_stage (
        .clk         (clk),
        .reset       (reset),
        .s2_valid    (s2_valid),
        .s2_kept     (s2_kept),
        .s2_round_up (s2_round_up),
        .out_valid   (out_valid),
        .out_sample  (out_sample)
    );

endmodule

// ==== testbench/requant_props.sv ====
// Requantizer pipeline properties
`timescale 1ns/1ps
`include "requant_settings.svh"

module requant_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      in_valid,
    input logic [`REQUANT_IN_W-1:0]  in_sample,
    input logic                      out_valid,
    input logic [`REQUANT_OUT_W-1:0] out_sample
);

    // Strobe history matching the three pipeline stages.
    logic [2:0] valid_hist;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[1:0], in_valid};
        end
    end

    valid_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid == valid_hist[2])
        else $error("out_valid does not follow in_valid by three cycles");

    reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid is high right after a reset cycle");

    full_scale: assert property (@(posedge clk) disable iff (reset)
        $past(in_valid && (&in_sample[`REQUANT_IN_W-1:`REQUANT_DROP_W]), 3)
        |-> (out_sample == '1))
        else $error("full scale input did not give an all ones output");

endmodule

// ==== testbench/requant_tb.sv ====
// Requantizer testbench
`timescale 1ns/1ps
`include "requant_settings.svh"

module requant_tb;

    localparam logic [`DITHER_LFSR_W-1:0] SEED = `DITHER_SEED;
    localparam logic [31:0] RNG_TAPS = 32'h8020_0003;
    localparam logic [`REQUANT_DROP_W-1:0] HALF_STEP = {1'b1, {(`REQUANT_DROP_W-1){1'b0}}};

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    logic [`REQUANT_IN_W-1:0]   in_sample;
    requant_pkg::requant_mode_t in_mode;
    logic                       out_valid;
    logic [`REQUANT_OUT_W-1:0]  out_sample;

    // The whole stimulus is built before reset ends, so the watchdog knows its length.
    logic [`REQUANT_IN_W-1:0]   stim_sample [$];
    requant_pkg::requant_mode_t stim_mode [$];
    int                         stim_gap [$];
    string                      stim_name [$];

    logic [`REQUANT_OUT_W-1:0]  exp_q [$];
    string                      name_q [$];

    logic [31:0]                rng;
    logic [`DITHER_LFSR_W-1:0]  ref_lfsr;
    int                         errors;
    int                         received;
    int                         reset_edges;
    int                         gap_total;
    bit                         stim_ready;

    requant_top DUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_mode    (in_mode),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    bind requant_top requant_props u_props (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? RNG_TAPS : 32'h0);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], rng[0]};
            rng   = galois_step(rng);
        end
    endtask

    // Expected output of one accepted sample. The model's dither LFSR steps here.
    function automatic logic [`REQUANT_OUT_W-1:0] reference_output(
        input logic [`REQUANT_IN_W-1:0] sample,
        input requant_pkg::requant_mode_t mode
    );
        logic [`REQUANT_OUT_W-1:0]  kept;
        logic [`REQUANT_DROP_W-1:0] dropped;
        logic [`REQUANT_DROP_W-1:0] threshold;
        logic                       up;
        logic [`REQUANT_OUT_W:0]    total;
        kept      = sample[`REQUANT_IN_W-1:`REQUANT_DROP_W];
        dropped   = sample[`REQUANT_DROP_W-1:0];
        threshold = ref_lfsr[`REQUANT_DROP_W-1:0];
        up        = 1'b0;
        if (mode == requant_pkg::MODE_ROUND) begin
            up = (dropped >= HALF_STEP);
        end else if (mode == requant_pkg::MODE_DITHER) begin
            up = (dropped > threshold);
        end
        if (ref_lfsr[0]) begin
            ref_lfsr = (ref_lfsr >> 1) ^ `DITHER_TAPS;
        end else begin
            ref_lfsr = ref_lfsr >> 1;
        end
        total = {1'b0, kept} + {{`REQUANT_OUT_W{1'b0}}, up};
        return total[`REQUANT_OUT_W] ? '1 : total[`REQUANT_OUT_W-1:0];
    endfunction

    task automatic add_sample(input logic [`REQUANT_IN_W-1:0] sample,
                              input requant_pkg::requant_mode_t mode,
                              input int gap, input string name);
        stim_sample.push_back(sample);
        stim_mode.push_back(mode);
        stim_gap.push_back(gap);
        stim_name.push_back(name);
        gap_total += gap;
    endtask

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name,
                                input logic [`REQUANT_OUT_W-1:0] expected,
                                input logic [`REQUANT_OUT_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            // Registers are unknown until the first reset edge.
            if (reset_edges > 0) begin
                check_flag("reset, out_valid held low", 1'b0, out_valid);
            end
            reset_edges++;
        end else if (out_valid) begin
            check_flag("strobe, out_valid with a sample pending", 1'b1, exp_q.size() != 0);
            check_sample(name_q.pop_front(), exp_q.pop_front(), out_sample);
            received++;
        end
    end

    initial begin
        int limit;
        wait (stim_ready);
        limit = stim_sample.size() + gap_total + 20;
        #(limit * 10);
        $display("Timeout: outputs stalled with %0d of %0d samples received",
                 received, stim_sample.size());
        stop_with_failure();
    end

    initial begin
        logic [31:0]                bits;
        logic [31:0]                extra;
        requant_pkg::requant_mode_t mode;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_sample   = '0;
        in_mode     = requant_pkg::MODE_TRUNCATE;
        rng         = 32'h4f50_42d5;
        ref_lfsr    = SEED;
        errors      = 0;
        received    = 0;
        reset_edges = 0;
        gap_total   = 0;
        stim_ready  = 1'b0;

        // Dropped bits equal to the seed's threshold must not round up.
        take_bits(`REQUANT_OUT_W, bits);
        add_sample({bits[`REQUANT_OUT_W-1:0], SEED[`REQUANT_DROP_W-1:0]},
                   requant_pkg::MODE_DITHER, 0, "reset");
        for (int i = 0; i < 40; i++) begin
            take_bits(`REQUANT_IN_W, bits);
            if (i == 0) bits[`REQUANT_DROP_W-1:0] = '0;
            if (i == 1) bits[`REQUANT_DROP_W-1:0] = '1;
            add_sample(bits[`REQUANT_IN_W-1:0], requant_pkg::MODE_TRUNCATE, 0, "truncate");
        end
        for (int i = 0; i < 42; i++) begin
            take_bits(`REQUANT_OUT_W, bits);
            extra = (i % 3 == 0) ? 32'd7 : ((i % 3 == 1) ? 32'd8 : 32'd15);
            add_sample({bits[`REQUANT_OUT_W-1:0], extra[`REQUANT_DROP_W-1:0]},
                       requant_pkg::MODE_ROUND, 0, "round");
        end
        for (int i = 0; i < 200; i++) begin
            take_bits(`REQUANT_IN_W, bits);
            take_bits(2, extra);
            add_sample(bits[`REQUANT_IN_W-1:0],
                       (extra == 0) ? requant_pkg::MODE_TRUNCATE :
                       ((extra == 1) ? requant_pkg::MODE_ROUND : requant_pkg::MODE_DITHER),
                       0, "dither");
        end
        for (int i = 0; i < 20; i++) begin
            take_bits(3, extra);
            if (i % 2 == 0) begin
                add_sample({{`REQUANT_OUT_W{1'b1}}, 1'b1, extra[2:0]},
                           requant_pkg::MODE_ROUND, 0, "saturation");
            end else begin
                add_sample('1, requant_pkg::MODE_DITHER, 0, "saturation");
            end
        end
        // Encoding 3 appears among the random modes and must act as truncate.
        for (int i = 0; i < 100; i++) begin
            take_bits(`REQUANT_IN_W, bits);
            take_bits(2, extra);
            mode = requant_pkg::requant_mode_t'(extra[1:0]);
            take_bits(1, extra);
            if (extra[0]) begin
                take_bits(2, extra);
                extra = extra + 1;
            end
            add_sample(bits[`REQUANT_IN_W-1:0], mode, extra, "strobe");
        end
        stim_ready = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < stim_sample.size(); i++) begin
            repeat (stim_gap[i]) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid  <= 1'b1;
            in_sample <= stim_sample[i];
            in_mode   <= stim_mode[i];
            exp_q.push_back(reference_output(stim_sample[i], stim_mode[i]));
            name_q.push_back(stim_name[i]);
        end
        @(posedge clk);
        in_valid <= 1'b0;

        // The last sample leaves three cycles after it was accepted.
        // The idle cycles after it expose any missing or stray output.
        repeat (6) @(posedge clk);
        check_flag("end of run, every sample returned", 1'b1,
                   (exp_q.size() == 0) && (received == stim_sample.size()));

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
design/requant_pkg.sv
design/prefix_adder.sv
design/dither_source.sv
design/requant_stage.sv
design/increment_stage.sv
design/requant_top.sv
testbench/requant_props.sv
testbench/requant_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module requant_tb -o requant_sim
	@out="$$(./obj_dir/requant_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
